//--- design/agcApbRegs.sv
//--------------------------------------------------------------------
// AGC APB register block
// Holds the loop configuration, latches the last completed level and
// returns configuration and status on reads. No wait states
//--------------------------------------------------------------------

`include "agc_config.svh"

module agcApbRegs import agcPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  agcApbReq    apbReq,
    output logic [31:0] prdata,
    output logic        pready,
    input  logic [31:0] integrator,
    input  agcLevel     level,
    output agcLoopCfg   loopCfg
);

    logic        access;
    logic        wrEn;
    agcRegAddr   regAddr;
    agcCtrl      ctrlReg;
    logic [7:0]  setpointReg;
    logic [4:0]  posGainReg;
    logic [4:0]  negGainReg;
    logic [31:0] upperReg;
    logic [31:0] lowerReg;
    logic [7:0]  lastLevel;
    logic [31:0] readData;

    assign access  = apbReq.psel && apbReq.penable;  // Access phase
    assign wrEn    = access && apbReq.pwrite;
    assign regAddr = agcRegAddr'(apbReq.paddr);
    assign pready  = 1'b1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctrlReg     <= '0;  // Loop disabled
            setpointReg <= '0;
            posGainReg  <= '0;
            negGainReg  <= '0;
            upperReg    <= `AGC_UPPER_RESET;
            lowerReg    <= `AGC_LOWER_RESET;
            lastLevel   <= '0;
        end else begin
            if (wrEn) begin
                case (regAddr)
                    CTRL:     ctrlReg     <= agcCtrl'(apbReq.pwdata[2:0]);
                    SETPOINT: setpointReg <= apbReq.pwdata[7:0];
                    GAIN: begin
                        posGainReg <= apbReq.pwdata[4:0];
                        negGainReg <= apbReq.pwdata[12:8];
                    end
                    UPPER:    upperReg    <= apbReq.pwdata;
                    LOWER:    lowerReg    <= apbReq.pwdata;
                    default: ;  // INTEG, LEVEL and holes ignore writes
                endcase
            end
            if (level.valid) begin
                lastLevel <= level.level;
            end
        end
    end

    // Read mux, unmapped addresses return zero
    always_comb begin
        case (regAddr)
            CTRL:     readData = {29'b0, ctrlReg};
            SETPOINT: readData = {24'b0, setpointReg};
            GAIN:     readData = {19'b0, negGainReg, 3'b0, posGainReg};
            UPPER:    readData = upperReg;
            LOWER:    readData = lowerReg;
            INTEG:    readData = integrator;
            LEVEL:    readData = {24'b0, lastLevel};
            default:  readData = '0;
        endcase
    end

    assign prdata = (access && !apbReq.pwrite) ? readData : '0;

    assign loopCfg.ctrl       = ctrlReg;
    assign loopCfg.setpoint   = setpointReg;
    assign loopCfg.posGain    = posGainReg;
    assign loopCfg.negGain    = negGainReg;
    assign loopCfg.upperLimit = upperReg;
    assign loopCfg.lowerLimit = lowerReg;

endmodule

//--- design/agcLevelDetector.sv
//--------------------------------------------------------------------
// AGC level detector
// Mean absolute value of signed 8-bit samples over a fixed window,
// one level with a single-cycle valid per window
//--------------------------------------------------------------------

`include "agc_config.svh"

module agcLevelDetector import agcPkg::*; #(
    parameter int WINDOW_LOG2 = `AGC_WINDOW_LOG2
) (
    input  logic              clk,
    input  logic              reset,
    input  logic signed [7:0] sampleIn,
    input  logic              sampleValid,
    output agcLevel           level
);

    // Worst case is 128 on every sample
    localparam int ACC_WIDTH = 8 + WINDOW_LOG2;

    logic [7:0]             magnitude;
    logic [WINDOW_LOG2-1:0] sampleCount;
    logic [ACC_WIDTH-1:0]   accum;
    logic [ACC_WIDTH-1:0]   windowSum;
    logic                   windowEnd;
    logic [7:0]             levelValue;
    logic                   levelValid;

    // -128 maps to 8'h80, still in range as unsigned
    assign magnitude = sampleIn[7] ? 8'(~sampleIn + 8'd1) : 8'(sampleIn);
    assign windowSum = accum + ACC_WIDTH'(magnitude);
    assign windowEnd = sampleValid && (sampleCount == '1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sampleCount <= '0;
            accum       <= '0;
            levelValid  <= 1'b0;
        end else begin
            levelValid <= windowEnd;  // High the cycle after the last sample
            if (sampleValid) begin
                sampleCount <= sampleCount + 1'b1;  // Wraps at window end
                accum       <= windowEnd ? '0 : windowSum;
            end
        end
    end

    // Divide by the window length
    always_ff @(posedge clk) begin
        if (windowEnd) begin
            levelValue <= windowSum[ACC_WIDTH-1:WINDOW_LOG2];
        end
    end

    assign level.level = levelValue;
    assign level.valid = levelValid;

endmodule

//--- design/agcLoopFilter.sv
//--------------------------------------------------------------------
// AGC loop filter
// Three-stage pipeline: error against the setpoint, shift gain chosen
// by error sign, then a 32-bit integrator clamped to the limits
//--------------------------------------------------------------------

module agcLoopFilter import agcPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  agcLoopCfg   loopCfg,
    input  agcLevel     level,
    output logic [31:0] integrator,
    output logic        loopValid
);

    logic [8:0]        diff;
    logic [8:0]        invDiff;
    logic signed [7:0] loopError;
    logic              errValid;
    logic [4:0]        loopGain;
    logic [31:0]       errorExt;
    logic [31:0]       leadNext;
    logic [31:0]       leadError;
    logic              leadValid;
    logic [32:0]       sum;
    logic [31:0]       integNext;

    // Stage 1, error formation

    // 9-bit differences, the upper 8 bits become the signed error
    assign diff    = {1'b0, loopCfg.setpoint} - {1'b0, level.level};
    assign invDiff = {1'b0, level.level} - {1'b0, loopCfg.setpoint};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            errValid <= 1'b0;
        end else begin
            errValid <= level.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (level.valid) begin
            if (loopCfg.ctrl.zeroError) begin
                loopError <= '0;
            end else if (loopCfg.ctrl.invertError) begin
                loopError <= invDiff[8:1];
            end else begin
                loopError <= diff[8:1];
            end
        end
    end

    // Stage 2, lead gain of 2**(gain-7)

    assign loopGain = loopError[7] ? loopCfg.negGain : loopCfg.posGain;
    assign errorExt = {{24{loopError[7]}}, loopError};

    always_comb begin
        if (loopGain >= 5'd7) begin
            leadNext = errorExt << (loopGain - 5'd7);
        end else begin
            // Arithmetic shift keeps small negative errors negative
            leadNext = 32'($signed(errorExt) >>> (5'd7 - loopGain));
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            leadValid <= 1'b0;
        end else begin
            leadValid <= errValid;
        end
    end

    always_ff @(posedge clk) begin
        if (errValid) begin
            leadError <= leadNext;
        end
    end

    // Stage 3, clamped integrator

    // Bit 32 flags a wrap below zero or a carry past the top
    assign sum = {1'b0, integrator} + {leadError[31], leadError};

    always_comb begin
        if (leadError[31] && sum[32]) begin
            integNext = loopCfg.lowerLimit;  // Wrapped past zero
        end else if (!leadError[31] && sum[32]) begin
            integNext = loopCfg.upperLimit;  // Overflowed upward
        end else if (sum[31:0] >= loopCfg.upperLimit) begin
            integNext = loopCfg.upperLimit;
        end else if (sum[31:0] <= loopCfg.lowerLimit) begin
            integNext = loopCfg.lowerLimit;
        end else begin
            integNext = sum[31:0];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            integrator <= '0;
            loopValid  <= 1'b0;
        end else begin
            loopValid <= leadValid;  // Pulses even with the loop frozen
            if (leadValid && loopCfg.ctrl.loopEnable) begin
                integrator <= integNext;
            end
        end
    end

endmodule

//--- design/agcPkg.sv
//--------------------------------------------------------------------
// AGC shared types
// Register address map, loop configuration, level report and the
// APB request bundle used across the AGC design and testbench
//--------------------------------------------------------------------

`include "agc_config.svh"

package agcPkg;

    // Word addresses of the register map
    typedef enum logic [`AGC_ADDR_WIDTH-1:0] {
        CTRL     = 'h00,
        SETPOINT = 'h04,
        GAIN     = 'h08,  // posGain in [4:0], negGain in [12:8]
        UPPER    = 'h0C,
        LOWER    = 'h10,
        INTEG    = 'h14,  // Read only, live integrator
        LEVEL    = 'h18   // Read only, last completed level
    } agcRegAddr;

    // CTRL register, loopEnable sits in bit 0
    typedef struct packed {
        logic invertError;  // Bit 2
        logic zeroError;    // Bit 1
        logic loopEnable;   // Bit 0
    } agcCtrl;

    // Loop filter configuration from the register block
    typedef struct packed {
        agcCtrl      ctrl;
        logic [7:0]  setpoint;
        logic [4:0]  posGain;
        logic [4:0]  negGain;
        logic [31:0] upperLimit;
        logic [31:0] lowerLimit;
    } agcLoopCfg;

    // One averaged level per window
    typedef struct packed {
        logic [7:0] level;
        logic       valid;
    } agcLevel;

    // APB request side
    typedef struct packed {
        logic                       psel;
        logic                       penable;
        logic                       pwrite;
        logic [`AGC_ADDR_WIDTH-1:0] paddr;
        logic [31:0]                pwdata;
    } agcApbReq;

endpackage

//--- design/agcTop.sv
//--------------------------------------------------------------------
// AGC top level
// Chain of level detector and loop filter, configured through the
// APB register block. The integrator is the gain output
//--------------------------------------------------------------------

`include "agc_config.svh"

module agcTop import agcPkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  agcApbReq          apbReq,
    output logic [31:0]       prdata,
    output logic              pready,
    input  logic signed [7:0] sampleIn,
    input  logic              sampleValid,
    output logic [31:0]       loopOutput,
    output logic              loopValid
);

    agcLoopCfg   loopCfg;     // Registers to loop filter
    agcLevel     level;       // Detector to filter and registers
    logic [31:0] integrator;  // Filter state, also read back over APB

    agcApbRegs u_regs (
        .clk        (clk),
        .reset      (reset),
        .apbReq     (apbReq),
        .prdata     (prdata),
        .pready     (pready),
        .integrator (integrator),
        .level      (level),
        .loopCfg    (loopCfg)
    );

    agcLevelDetector #(
        .WINDOW_LOG2 (`AGC_WINDOW_LOG2)
    ) u_detector (
        .clk         (clk),
        .reset       (reset),
        .sampleIn    (sampleIn),
        .sampleValid (sampleValid),
        .level       (level)
    );

    agcLoopFilter u_loopFilter (
        .clk        (clk),
        .reset      (reset),
        .loopCfg    (loopCfg),
        .level      (level),
        .integrator (integrator),
        .loopValid  (loopValid)
    );

    assign loopOutput = integrator;

endmodule

//--- design/agc_config.svh
//--------------------------------------------------------------------
// AGC configuration macros
// Window length, APB address width and register reset values shared
// by the AGC design and its testbench
//--------------------------------------------------------------------

`ifndef AGC_CONFIG_SVH
`define AGC_CONFIG_SVH

// Samples per level window as a power of two (4 gives 16 samples)
`define AGC_WINDOW_LOG2 4

// APB word address width, covers the register map up to 0x1C
`define AGC_ADDR_WIDTH 5

// Integrator limit registers after reset
`define AGC_UPPER_RESET 32'hFF00_0000
`define AGC_LOWER_RESET 32'h0100_0000

`endif

//--- files.f
+incdir+design
design/agcPkg.sv
design/agcApbRegs.sv
design/agcLevelDetector.sv
design/agcLoopFilter.sv
design/agcTop.sv
sim/agc_assertions.sv
sim/agcTb.sv

//--- run.sh
#!/bin/sh
# Build the AGC testbench with Verilator, run it and search for the pass line
verilator --binary --timing --assert -f files.f --top-module agcTb -o agcSim \
    || { echo "Verilator build failed"; exit 1; }
result="$(./obj_dir/agcSim)"
printf '%s\n' "$result"
printf '%s\n' "$result" | grep -qx "TEST OK" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- sim/agcTb.sv
//----------------------------------------------------------------------
// AGC testbench
// Replays a command file of APB writes, checked APB reads and sample
// windows, and checks the integrator after every completed window
//----------------------------------------------------------------------

`include "agc_config.svh"

module agcTb import agcPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WINDOW       = 1 << `AGC_WINDOW_LOG2;
    localparam int RESET_CYCLES = 16;
    localparam int PERIOD_NS    = 40;

    logic              clk = 1'b0;
    logic              reset;
    agcApbReq          apbReq;
    logic [31:0]       prdata;
    logic              pready;
    logic signed [7:0] sampleIn;
    logic              sampleValid;
    logic [31:0]       loopOutput;
    logic              loopValid;

    // Parsed command file
    logic [7:0]  cmdList[$];
    logic [31:0] argA[$];      // Address or sample value
    logic [31:0] argB[$];      // Write data or expected value
    int          argCount[$];
    int          argAlt[$];

    int     readErrors   = 0;
    int     readyErrors  = 0;
    int     loopErrors   = 0;
    int     levelErrors  = 0;
    int     missingValid = 0;
    int     fileErrors   = 0;
    int     windowPos    = 0;             // Valid samples into the current window
    longint budgetCycles = RESET_CYCLES;
    bit     loaded       = 1'b0;

    always #(PERIOD_NS / 2) clk = ~clk;

    agcTop u_agcTop (
        .clk         (clk),
        .reset       (reset),
        .apbReq      (apbReq),
        .prdata      (prdata),
        .pready      (pready),
        .sampleIn    (sampleIn),
        .sampleValid (sampleValid),
        .loopOutput  (loopOutput),
        .loopValid   (loopValid)
    );

    task automatic checkReadData(input logic [`AGC_ADDR_WIDTH-1:0] addr,
                                 input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            readErrors++;
            $display("ERR %0d ns: read of 0x%02h gave 0x%08h, expected 0x%08h",
                     $time, addr, got, expected);
        end
    endtask

    // No wait states, so every access cycle must see pready high
    task automatic checkReady(input logic got);
        if (got !== 1'b1) begin
            readyErrors++;
            $display("ERR %0d ns: pready is %b in the APB access cycle", $time, got);
        end
    endtask

    task automatic checkLoopOutput(input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            loopErrors++;
            $display("ERR %0d ns: loopOutput 0x%08h, expected 0x%08h", $time, got, expected);
        end
    endtask

    task automatic checkLevel(input agcLevel got, input agcLevel expected);
        if (got !== expected) begin
            levelErrors++;
            $display("ERR %0d ns: level 0x%02h (clean %0b), expected 0x%02h",
                     $time, got.level, got.valid, expected.level);
        end
    endtask

    task automatic apbWrite(input logic [`AGC_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        apbReq.psel    <= 1'b1;
        apbReq.penable <= 1'b0;
        apbReq.pwrite  <= 1'b1;
        apbReq.paddr   <= addr;
        apbReq.pwdata  <= data;
        @(posedge clk);
        apbReq.penable <= 1'b1;  // Write lands at the next edge
        @(negedge clk);
        checkReady(pready);
        @(posedge clk);
        apbReq.psel    <= 1'b0;
        apbReq.penable <= 1'b0;
    endtask

    task automatic apbRead(input logic [`AGC_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
        @(posedge clk);
        apbReq.psel    <= 1'b1;
        apbReq.penable <= 1'b0;
        apbReq.pwrite  <= 1'b0;
        apbReq.paddr   <= addr;
        @(posedge clk);
        apbReq.penable <= 1'b1;
        @(negedge clk);
        data = prdata;           // Mid access cycle
        checkReady(pready);
        @(posedge clk);
        apbReq.psel    <= 1'b0;
        apbReq.penable <= 1'b0;
    endtask

    task automatic readAndCheck(input logic [`AGC_ADDR_WIDTH-1:0] addr,
                                input logic [31:0] expected);
        logic [31:0] data;
        agcLevel     gotLevel;
        agcLevel     expLevel;
        apbRead(addr, data);
        if (addr == LEVEL) begin
            gotLevel.level = data[7:0];
            gotLevel.valid = (data[31:8] == '0);  // Upper bits must read zero
            expLevel.level = expected[7:0];
            expLevel.valid = 1'b1;
            checkLevel(gotLevel, expLevel);
        end else begin
            checkReadData(addr, data, expected);
        end
    endtask

    // Result appears four cycles after the last sample of a window
    task automatic awaitLoopResult(input logic [31:0] expected);
        int n;
        bit seen;
        seen = 1'b0;
        for (n = 0; n < 4 && !seen; n++) begin
            @(negedge clk);
            if (loopValid) begin
                seen = 1'b1;
                checkLoopOutput(loopOutput, expected);
            end
        end
        if (!seen) begin
            missingValid++;
            $display("No loopValid within four cycles of the window ending near %0d ns", $time);
        end
    endtask

    task automatic driveWindow(input logic [7:0] value, input int count, input int alt,
                               input logic [31:0] expected);
        int         i;
        logic [7:0] sample;
        for (i = 0; i < count; i++) begin
            @(posedge clk);
            sample = (alt != 0 && i % 2 == 1) ? 8'(-value) : value;  // Odd samples negated
            sampleIn    <= sample;
            sampleValid <= 1'b1;
            windowPos = (windowPos + 1) % WINDOW;
        end
        @(posedge clk);
        sampleValid <= 1'b0;
        if (windowPos == 0) begin
            awaitLoopResult(expected);
        end
    endtask

    task automatic loadCommands();
        int          fd;
        int          fields;
        string       line;
        logic [7:0]  cmd;
        logic [31:0] a;
        logic [31:0] b;
        int          count;
        int          alt;
        bit          wellFormed;
        fd = $fopen("sim/agc_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the command file sim/agc_testdata.txt");
            fileErrors++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            cmd   = line[0];
            count = 0;
            alt   = 0;
            if (cmd == "S") begin
                fields     = $sscanf(line, "%c %h %d %d %h", cmd, a, count, alt, b);
                wellFormed = (fields == 5);
            end else begin
                fields     = $sscanf(line, "%c %h %h", cmd, a, b);
                wellFormed = (fields == 3) && (cmd inside {"W", "R"});
            end
            if (!wellFormed) begin
                $display("Malformed line in the command file: %s", line);
                fileErrors++;
                continue;
            end
            cmdList.push_back(cmd);
            argA.push_back(a);
            argB.push_back(b);
            argCount.push_back(count);
            argAlt.push_back(alt);
            budgetCycles += 10 + count;
        end
        $fclose(fd);
        if (cmdList.size() == 0) begin
            $display("The command file holds no commands");
            fileErrors++;
        end
    endtask

    initial begin
        logic [`AGC_ADDR_WIDTH-1:0] addr;
        reset       <= 1'b1;
        apbReq      <= '0;
        sampleIn    <= '0;
        sampleValid <= 1'b0;
        loadCommands();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        foreach (cmdList[i]) begin
            addr = argA[i][`AGC_ADDR_WIDTH-1:0];
            case (cmdList[i])
                "W":     apbWrite(addr, argB[i]);
                "R":     readAndCheck(addr, argB[i]);
                default: driveWindow(argA[i][7:0], argCount[i], argAlt[i], argB[i]);
            endcase
        end
        repeat (2) @(posedge clk);
        $display({"Errors: read %0d, pready %0d, loop output %0d, level %0d, ",
                  "missing loopValid %0d, file %0d"},
                 readErrors, readyErrors, loopErrors, levelErrors, missingValid, fileErrors);
        if (readErrors + readyErrors + loopErrors + levelErrors + missingValid
                + fileErrors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog, sized from the commands once they are loaded
    initial begin
        wait (loaded);
        #(budgetCycles * PERIOD_NS);
        $display("Watchdog expired: commands did not finish within %0d cycles", budgetCycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- sim/agc_assertions.sv
//----------------------------------------------------------------------
// AGC assertions
// Bound into the AGC top level: APB phase order, integrator inside the
// programmed limits and no loop result right after reset
//----------------------------------------------------------------------

`include "agc_config.svh"

module agcAssertions import agcPkg::*; (
    input logic        clk,
    input logic        reset,
    input agcApbReq    apbReq,
    input agcLoopCfg   loopCfg,
    input logic [31:0] loopOutput,
    input logic        loopValid
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] upperPrev;
    logic [31:0] lowerPrev;
    logic        limitsChanged;
    logic        settled;      // Clamped result seen since the last limit change
    logic [1:0]  sinceReset;   // Saturates at 3

    assign limitsChanged = (loopCfg.upperLimit != upperPrev) ||
                           (loopCfg.lowerLimit != lowerPrev);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            upperPrev  <= `AGC_UPPER_RESET;
            lowerPrev  <= `AGC_LOWER_RESET;
            settled    <= 1'b0;
            sinceReset <= '0;
        end else begin
            upperPrev <= loopCfg.upperLimit;
            lowerPrev <= loopCfg.lowerLimit;
            if (limitsChanged) begin
                settled <= 1'b0;
            end else if (loopValid && loopCfg.ctrl.loopEnable) begin
                settled <= 1'b1;
            end
            if (sinceReset != 2'd3) begin
                sinceReset <= sinceReset + 2'd1;
            end
        end
    end

    penableAfterSetup: assert property (@(posedge clk) disable iff (reset)
        apbReq.penable |-> apbReq.psel && $past(apbReq.psel && !apbReq.penable))
        else $error("APB penable high without a preceding setup cycle");

    integInLimits: assert property (@(posedge clk) disable iff (reset)
        settled && !limitsChanged |->
            loopOutput >= loopCfg.lowerLimit && loopOutput <= loopCfg.upperLimit)
        else $error("loopOutput 0x%08h outside the programmed limits", loopOutput);

    noEarlyValid: assert property (@(posedge clk) disable iff (reset)
        sinceReset != 2'd3 |-> !loopValid)
        else $error("loopValid within three cycles of reset release");

endmodule

bind agcTop agcAssertions u_assertions (
    .clk        (clk),
    .reset      (reset),
    .apbReq     (apbReq),
    .loopCfg    (loopCfg),
    .loopOutput (loopOutput),
    .loopValid  (loopValid)
);

//--- sim/agc_testdata.txt
# W addr data | R addr expected (addr and data in hex)
# S sample(hex) count(dec) alternate(dec, 1 negates odd samples) expected integrator(hex)
# The expected integrator is checked when the line completes a 16-sample window
R 00 00000000
R 04 00000000
R 08 00000000
R 0c ff000000
R 10 01000000
R 14 00000000
R 18 00000000
W 04 00000040
R 04 00000040
W 08 00000509
R 08 00000509
W 0c 00100000
R 0c 00100000
W 10 00000010
R 10 00000010
W 00 00000006
R 00 00000006
W 14 12345678
R 14 00000000
W 18 000000ff
R 18 00000000
W 1c deadbeef
R 1c 00000000
S 20 16 0 00000000
R 18 00000020
S 32 16 1 00000000
R 18 00000032
S 80 16 0 00000000
R 18 00000080
W 00 00000001
S 10 16 0 00000060
S 08 16 1 000000d0
S 70 16 0 000000ca
S 43 16 0 000000c9
R 18 00000043
W 08 00000707
S 20 16 0 000000d9
S 7f 16 0 000000b9
W 08 0000030c
S 30 16 0 000001b9
S 50 16 0 000001b8
R 14 000001b8
W 0c 00004000
W 10 00000100
W 08 00001414
S 00 16 0 00004000
S 80 16 0 00000100
W 08 00000707
S 50 16 0 00000100
S 00 16 0 00000120
W 00 00000003
S 10 16 0 00000120
W 00 00000005
S 60 16 0 00000130
W 00 00000000
S 00 16 0 00000130
R 14 00000130
W 0c ffffffff
W 10 ffff0000
W 08 00001414
W 00 00000001
S 00 16 0 ffff0000
S 00 16 0 ffffffff
R 14 ffffffff
R 18 00000000
